//--- rv_config.svh
`default_nettype none

`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// width of instruction and data words
`define RV_XLEN 32

// fetch buffer entries, also the number of fetch credits
`define RV_BUF_DEPTH 4

// first instruction address after reset
`define RV_RESET_PC 32'h0000_0000

// machine CSR addresses used by the trap instructions
// ecall reads the trap vector
`define RV_CSR_MTVEC 12'h305

// ecall saves the pc here, mret reads it back
`define RV_CSR_MEPC 12'h341

// ecall writes the trap cause
`define RV_CSR_MCAUSE 12'h342

`endif

`default_nettype wire

//--- rv_pkg.sv
`include "rv_config.svh"
`default_nettype none

package rv_pkg;

  // instruction or data word
  typedef logic [`RV_XLEN-1:0] word_t;

  // byte address, also used for the pc
  typedef logic [31:0] addr_t;

  // architectural register index x0..x31
  typedef logic [4:0] reg_idx_t;

  // csr address space
  typedef logic [11:0] csr_addr_t;

  // alu operation, one bit per function group
  // bit 0 sub and compares, bit 1 xor and beq, bit 2 or, bne and csrrs
  // bit 3 and plus unsigned compares, bit 4 sll and bgeu
  // bit 5 srl plus signed less-than, bit 6 sra and bge, bit 7 csrrc
  // all zero selects add
  typedef logic [7:0] alu_op_t;

  // next pc select
  // bit 0 jal or branch, bit 1 jalr or branch, bit 2 ecall or mret
  typedef logic [2:0] npc_sel_t;

  // register write-back source
  // bit 0 link or load, bit 1 auipc or load, bit 2 csr read
  typedef logic [2:0] wdata_sel_t;

  // alu operand 2 source
  // bit 0 immediate, bit 1 csr value
  typedef logic [1:0] opnd_sel_t;

  // event counter
  typedef logic [31:0] count_t;

  // fetch unit state machine
  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_RUN  = 1'b1
  } fetch_state_t;

endpackage

`default_nettype wire

//--- inst_fetch.sv
`timescale 1ns/1ps
`include "rv_config.svh"
`default_nettype none

module inst_fetch
  import rv_pkg::*;
(
  input  logic  clock,
  input  logic  arst_n,
  input  logic  run,
  input  logic  pop,
  output logic  imem_req,
  output addr_t imem_addr,
  input  word_t imem_rdata,
  output logic  push,
  output word_t push_inst,
  output addr_t push_pc
);

  localparam int CREDIT_W = $clog2(`RV_BUF_DEPTH + 1);
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`RV_BUF_DEPTH);

  fetch_state_t        state;
  addr_t               pc;
  logic [CREDIT_W-1:0] credits;
  logic                rdata_valid;
  addr_t               req_pc;

  // one read per cycle as long as buffer space is reserved
  assign imem_req  = (state == FETCH_RUN) && (credits != '0);
  assign imem_addr = pc;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state       <= FETCH_IDLE;
      pc          <= `RV_RESET_PC;
      credits     <= CREDIT_MAX;
      rdata_valid <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (run) begin
            state <= FETCH_RUN;
          end
        end
        FETCH_RUN: begin
          if (!run) begin
            state <= FETCH_IDLE;
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase

      // a request takes a credit, a pop downstream gives one back
      case ({imem_req, pop})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase

      if (imem_req) begin
        pc <= pc + 32'd4;
      end

      // memory answers exactly one cycle later
      rdata_valid <= imem_req;
    end
  end

  // address of the read in flight, paired with its data on return
  always_ff @(posedge clock) begin
    if (imem_req) begin
      req_pc <= pc;
    end
  end

  assign push      = rdata_valid;
  assign push_inst = imem_rdata;
  assign push_pc   = req_pc;

endmodule

`default_nettype wire

//--- fetch_buffer.sv
`timescale 1ns/1ps
`include "rv_config.svh"
`default_nettype none

module fetch_buffer
  import rv_pkg::*;
(
  input  logic  clock,
  input  logic  arst_n,
  input  logic  push,
  input  word_t push_inst,
  input  addr_t push_pc,
  input  logic  pop,
  output logic  empty,
  output word_t head_inst,
  output addr_t head_pc
);

  localparam int DEPTH   = `RV_BUF_DEPTH;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

  word_t inst_mem [DEPTH];
  addr_t pc_mem   [DEPTH];

  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;

  // storage, written at the tail
  always_ff @(posedge clock) begin
    if (push) begin
      inst_mem[wr_ptr] <= push_inst;
      pc_mem[wr_ptr]   <= push_pc;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves occupancy unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // fetch credits keep the buffer from overflowing, so no full flag
  assign empty     = (count == '0);
  assign head_inst = inst_mem[rd_ptr];
  assign head_pc   = pc_mem[rd_ptr];

endmodule

`default_nettype wire

//--- inst_decode.sv
`timescale 1ns/1ps
`include "rv_config.svh"
`default_nettype none

module inst_decode
  import rv_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       stall,
  input  logic       empty,
  input  word_t      head_inst,
  input  addr_t      head_pc,
  output logic       pop,
  output logic       dec_valid,
  output addr_t      dec_pc,
  output npc_sel_t   npc_sel,
  output word_t      imm,
  output opnd_sel_t  alu_operand2_sel,
  output logic       suffix_b,
  output logic       suffix_h,
  output logic       sext,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output logic       r_wen,
  output wdata_sel_t r_wdata_sel,
  output csr_addr_t  csr_s,
  output csr_addr_t  csr_d1,
  output csr_addr_t  csr_d2,
  output logic       csr_wen1,
  output logic       csr_wen2,
  output logic       csr_wdata1_sel,
  output logic       csr_wdata2_sel,
  output logic       mem_ren,
  output logic       mem_wen,
  output alu_op_t    alu_opcode,
  output count_t     count_calc,
  output count_t     count_ls,
  output count_t     count_csr
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;

  logic is_lui, is_auipc, is_jal, is_jalr, is_branch;
  logic is_load, is_store, is_op_imm, is_op, is_system;
  logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
  logic is_lb, is_lh, is_lbu, is_lhu, is_sb, is_sh;
  logic is_slti, is_sltiu, is_xori, is_ori, is_andi;
  logic is_slli, is_srli, is_srai;
  logic is_sub, is_sll, is_slt, is_sltu, is_xor, is_srl, is_sra, is_or, is_and;
  logic is_csrrw, is_csrrs, is_csrrc, is_csr_op, is_ecall, is_mret;
  logic u_type, j_type, b_type, i_type, s_type, r_type;

  word_t      imm_nxt;
  npc_sel_t   npc_sel_nxt;
  opnd_sel_t  opnd_sel_nxt;
  wdata_sel_t wdata_sel_nxt;
  alu_op_t    alu_op_nxt;
  logic       calc_class;
  logic       ls_class;

  assign opcode  = head_inst[6:0];
  assign funct3  = head_inst[14:12];
  assign funct7  = head_inst[31:25];
  assign f7_base = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // major opcodes
  assign is_lui    = (opcode == 7'b0110111);
  assign is_auipc  = (opcode == 7'b0010111);
  assign is_jal    = (opcode == 7'b1101111);
  assign is_jalr   = (opcode == 7'b1100111) && (funct3 == 3'b000);
  assign is_branch = (opcode == 7'b1100011);
  assign is_load   = (opcode == 7'b0000011);
  assign is_store  = (opcode == 7'b0100011);
  assign is_op_imm = (opcode == 7'b0010011);
  assign is_op     = (opcode == 7'b0110011);
  assign is_system = (opcode == 7'b1110011);

  assign is_beq  = is_branch && (funct3 == 3'b000);
  assign is_bne  = is_branch && (funct3 == 3'b001);
  assign is_blt  = is_branch && (funct3 == 3'b100);
  assign is_bge  = is_branch && (funct3 == 3'b101);
  assign is_bltu = is_branch && (funct3 == 3'b110);
  assign is_bgeu = is_branch && (funct3 == 3'b111);

  // only the byte and halfword forms need their own select
  assign is_lb  = is_load && (funct3 == 3'b000);
  assign is_lh  = is_load && (funct3 == 3'b001);
  assign is_lbu = is_load && (funct3 == 3'b100);
  assign is_lhu = is_load && (funct3 == 3'b101);
  assign is_sb  = is_store && (funct3 == 3'b000);
  assign is_sh  = is_store && (funct3 == 3'b001);

  assign is_slti  = is_op_imm && (funct3 == 3'b010);
  assign is_sltiu = is_op_imm && (funct3 == 3'b011);
  assign is_xori  = is_op_imm && (funct3 == 3'b100);
  assign is_ori   = is_op_imm && (funct3 == 3'b110);
  assign is_andi  = is_op_imm && (funct3 == 3'b111);
  assign is_slli  = is_op_imm && (funct3 == 3'b001) && f7_base;
  assign is_srli  = is_op_imm && (funct3 == 3'b101) && f7_base;
  assign is_srai  = is_op_imm && (funct3 == 3'b101) && f7_alt;

  // RV32M encodings (funct7 = 1) are not decoded
  assign is_sub  = is_op && (funct3 == 3'b000) && f7_alt;
  assign is_sll  = is_op && (funct3 == 3'b001) && f7_base;
  assign is_slt  = is_op && (funct3 == 3'b010) && f7_base;
  assign is_sltu = is_op && (funct3 == 3'b011) && f7_base;
  assign is_xor  = is_op && (funct3 == 3'b100) && f7_base;
  assign is_srl  = is_op && (funct3 == 3'b101) && f7_base;
  assign is_sra  = is_op && (funct3 == 3'b101) && f7_alt;
  assign is_or   = is_op && (funct3 == 3'b110) && f7_base;
  assign is_and  = is_op && (funct3 == 3'b111) && f7_base;

  assign is_csrrw  = is_system && (funct3 == 3'b001);
  assign is_csrrs  = is_system && (funct3 == 3'b010);
  assign is_csrrc  = is_system && (funct3 == 3'b011);
  assign is_csr_op = is_csrrw || is_csrrs || is_csrrc;
  assign is_ecall  = (head_inst == 32'h0000_0073);
  assign is_mret   = (head_inst == 32'h3020_0073);

  assign u_type = is_lui || is_auipc;
  assign j_type = is_jal;
  assign b_type = is_branch;
  assign i_type = is_jalr || is_load || is_op_imm || is_csr_op;
  assign s_type = is_store;
  assign r_type = is_op;

  // at most one format is active, so the immediates are merged by or
  assign imm_nxt =
      (u_type ? {head_inst[31:12], 12'b0} : '0) |
      (j_type ? {{12{head_inst[31]}}, head_inst[19:12], head_inst[20],
                 head_inst[30:21], 1'b0} : '0) |
      (b_type ? {{20{head_inst[31]}}, head_inst[7], head_inst[30:25],
                 head_inst[11:8], 1'b0} : '0) |
      (i_type ? {{20{head_inst[31]}}, head_inst[31:20]} : '0) |
      (s_type ? {{20{head_inst[31]}}, head_inst[31:25], head_inst[11:7]} : '0);

  assign npc_sel_nxt = {is_ecall || is_mret, is_jalr || is_branch, is_jal || is_branch};

  assign opnd_sel_nxt = {is_csrrs || is_csrrc,
                         is_lui || is_jalr || is_load || is_op_imm || s_type};

  assign wdata_sel_nxt = {is_csr_op, is_auipc || is_load, is_jal || is_jalr || is_load};

  assign alu_op_nxt[0] = is_sub || is_branch || is_slti || is_sltiu || is_slt || is_sltu;
  assign alu_op_nxt[1] = is_xori || is_xor || is_beq;
  assign alu_op_nxt[2] = is_ori || is_or || is_bne || is_csrrs;
  assign alu_op_nxt[3] = is_andi || is_and || is_bltu || is_sltiu || is_sltu;
  assign alu_op_nxt[4] = is_slli || is_sll || is_bgeu;
  assign alu_op_nxt[5] = is_srli || is_srl || is_blt || is_slti || is_slt;
  assign alu_op_nxt[6] = is_srai || is_sra || is_bge;
  assign alu_op_nxt[7] = is_csrrc;

  assign calc_class = is_lui || is_auipc || is_jal || is_jalr || is_op_imm || is_op;
  assign ls_class   = is_load || is_store;

  // take the head word whenever one is waiting and we are not held
  assign pop = !empty && !stall;

  // strobes and counters
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid  <= 1'b0;
      r_wen      <= 1'b0;
      csr_wen1   <= 1'b0;
      csr_wen2   <= 1'b0;
      mem_ren    <= 1'b0;
      mem_wen    <= 1'b0;
      count_calc <= '0;
      count_ls   <= '0;
      count_csr  <= '0;
    end else begin
      dec_valid <= pop;
      r_wen     <= (u_type || j_type || i_type || r_type) && pop;
      csr_wen1  <= (is_csr_op || is_ecall) && pop;
      csr_wen2  <= is_ecall && pop;
      mem_ren   <= is_load && pop;
      mem_wen   <= is_store && pop;
      if (pop && calc_class) begin
        count_calc <= count_calc + 1'b1;
      end
      if (pop && ls_class) begin
        count_ls <= count_ls + 1'b1;
      end
      if (pop && is_system) begin
        count_csr <= count_csr + 1'b1;
      end
    end
  end

  // decoded fields, held until the next pop
  always_ff @(posedge clock) begin
    if (pop) begin
      dec_pc           <= head_pc;
      npc_sel          <= npc_sel_nxt;
      imm              <= imm_nxt;
      alu_operand2_sel <= opnd_sel_nxt;
      suffix_b         <= is_lb || is_lbu || is_sb;
      suffix_h         <= is_lh || is_lhu || is_sh;
      sext             <= is_lb || is_lh;
      // lui adds its immediate to x0, csrrw passes the csr through with x0
      rs1              <= is_lui ? '0 : head_inst[19:15];
      rs2              <= is_csrrw ? '0 : head_inst[24:20];
      rd               <= head_inst[11:7];
      r_wdata_sel      <= wdata_sel_nxt;
      csr_s            <= is_ecall ? `RV_CSR_MTVEC : (is_mret ? `RV_CSR_MEPC : imm_nxt[11:0]);
      csr_d1           <= is_ecall ? `RV_CSR_MCAUSE : imm_nxt[11:0];
      csr_d2           <= is_ecall ? `RV_CSR_MEPC : imm_nxt[11:0];
      csr_wdata1_sel   <= is_ecall;
      csr_wdata2_sel   <= is_ecall;
      alu_opcode       <= alu_op_nxt;
    end
  end

endmodule

`default_nettype wire

//--- frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top
  import rv_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       run,
  input  logic       stall,
  output logic       imem_req,
  output addr_t      imem_addr,
  input  word_t      imem_rdata,
  output logic       dec_valid,
  output addr_t      dec_pc,
  output npc_sel_t   npc_sel,
  output word_t      imm,
  output opnd_sel_t  alu_operand2_sel,
  output logic       suffix_b,
  output logic       suffix_h,
  output logic       sext,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output logic       r_wen,
  output wdata_sel_t r_wdata_sel,
  output csr_addr_t  csr_s,
  output csr_addr_t  csr_d1,
  output csr_addr_t  csr_d2,
  output logic       csr_wen1,
  output logic       csr_wen2,
  output logic       csr_wdata1_sel,
  output logic       csr_wdata2_sel,
  output logic       mem_ren,
  output logic       mem_wen,
  output alu_op_t    alu_opcode,
  output count_t     count_calc,
  output count_t     count_ls,
  output count_t     count_csr
);

  // fetch to buffer
  logic  push;
  word_t push_inst;
  addr_t push_pc;

  // buffer to decoder, pop also returns a fetch credit
  logic  pop;
  logic  empty;
  word_t head_inst;
  addr_t head_pc;

  inst_fetch fetch0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .run        (run),
    .pop        (pop),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .push       (push),
    .push_inst  (push_inst),
    .push_pc    (push_pc)
  );

  fetch_buffer buffer0 (
    .clock     (clock),
    .arst_n    (arst_n),
    .push      (push),
    .push_inst (push_inst),
    .push_pc   (push_pc),
    .pop       (pop),
    .empty     (empty),
    .head_inst (head_inst),
    .head_pc   (head_pc)
  );

  inst_decode decode0 (
    .clock            (clock),
    .arst_n           (arst_n),
    .stall            (stall),
    .empty            (empty),
    .head_inst        (head_inst),
    .head_pc          (head_pc),
    .pop              (pop),
    .dec_valid        (dec_valid),
    .dec_pc           (dec_pc),
    .npc_sel          (npc_sel),
    .imm              (imm),
    .alu_operand2_sel (alu_operand2_sel),
    .suffix_b         (suffix_b),
    .suffix_h         (suffix_h),
    .sext             (sext),
    .rs1              (rs1),
    .rs2              (rs2),
    .rd               (rd),
    .r_wen            (r_wen),
    .r_wdata_sel      (r_wdata_sel),
    .csr_s            (csr_s),
    .csr_d1           (csr_d1),
    .csr_d2           (csr_d2),
    .csr_wen1         (csr_wen1),
    .csr_wen2         (csr_wen2),
    .csr_wdata1_sel   (csr_wdata1_sel),
    .csr_wdata2_sel   (csr_wdata2_sel),
    .mem_ren          (mem_ren),
    .mem_wen          (mem_wen),
    .alu_opcode       (alu_opcode),
    .count_calc       (count_calc),
    .count_ls         (count_ls),
    .count_csr        (count_csr)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
  end

  // free running, first rising edge at half a period
  always begin
    #(PERIOD_NS / 2.0);
    clock = ~clock;
  end

endmodule

`default_nettype wire

//--- tb_decode_table.svh
`ifndef TB_DECODE_TABLE_SVH
`define TB_DECODE_TABLE_SVH

// each row holds inst, imm, rs1, rs2, rd, alu_opcode, r_wen, r_wdata_sel, mem_ren,
// mem_wen, csr_s, csr_d1, npc_sel, class (0 computation, 1 load/store, 2 system, 3 none),
// alu_operand2_sel and the access size bits {suffix_b, suffix_h, sext}

localparam int NUM_ROWS = 16;

logic [31:0] t_inst  [NUM_ROWS];
logic [31:0] t_imm   [NUM_ROWS];
logic [4:0]  t_rs1   [NUM_ROWS];
logic [4:0]  t_rs2   [NUM_ROWS];
logic [4:0]  t_rd    [NUM_ROWS];
logic [7:0]  t_alu   [NUM_ROWS];
logic        t_rwen  [NUM_ROWS];
logic [2:0]  t_wsel  [NUM_ROWS];
logic        t_mren  [NUM_ROWS];
logic        t_mwen  [NUM_ROWS];
logic [11:0] t_csr_s [NUM_ROWS];
logic [11:0] t_csr_d [NUM_ROWS];
logic [2:0]  t_npc   [NUM_ROWS];
int          t_class [NUM_ROWS];
logic [1:0]  t_opnd  [NUM_ROWS];
logic [2:0]  t_size  [NUM_ROWS];
int          rows_filled = 0;

task automatic add_row(input logic [31:0] inst, input logic [31:0] imm_v,
                       input logic [4:0] rs1_v, input logic [4:0] rs2_v,
                       input logic [4:0] rd_v, input logic [7:0] alu_v, input logic rwen_v,
                       input logic [2:0] wsel_v, input logic mren_v, input logic mwen_v,
                       input logic [11:0] csr_s_v, input logic [11:0] csr_d_v,
                       input logic [2:0] npc_v, input int class_v,
                       input logic [1:0] opnd_v, input logic [2:0] size_v);
  t_inst[rows_filled]  = inst;
  t_imm[rows_filled]   = imm_v;
  t_rs1[rows_filled]   = rs1_v;
  t_rs2[rows_filled]   = rs2_v;
  t_rd[rows_filled]    = rd_v;
  t_alu[rows_filled]   = alu_v;
  t_rwen[rows_filled]  = rwen_v;
  t_wsel[rows_filled]  = wsel_v;
  t_mren[rows_filled]  = mren_v;
  t_mwen[rows_filled]  = mwen_v;
  t_csr_s[rows_filled] = csr_s_v;
  t_csr_d[rows_filled] = csr_d_v;
  t_npc[rows_filled]   = npc_v;
  t_class[rows_filled] = class_v;
  t_opnd[rows_filled]  = opnd_v;
  t_size[rows_filled]  = size_v;
  rows_filled++;
endtask

task automatic fill_table();
  // lui x5,0x12345 / addi x1,x0,-5 / add x3,x1,x2 / sub x4,x3,x1
  add_row(32'h123452B7, 32'h12345000, 0, 3, 5, 8'h00, 1, 3'b000, 0, 0,
          12'h000, 12'h000, 3'b000, 0, 2'b01, 3'b000);
  add_row(32'hFFB00093, 32'hFFFFFFFB, 0, 27, 1, 8'h00, 1, 3'b000, 0, 0,
          12'hFFB, 12'hFFB, 3'b000, 0, 2'b01, 3'b000);
  add_row(32'h002081B3, 32'h00000000, 1, 2, 3, 8'h00, 1, 3'b000, 0, 0,
          12'h000, 12'h000, 3'b000, 0, 2'b00, 3'b000);
  add_row(32'h40118233, 32'h00000000, 3, 1, 4, 8'h01, 1, 3'b000, 0, 0,
          12'h000, 12'h000, 3'b000, 0, 2'b00, 3'b000);
  // srai x6,x1,3 / lh x7,-8(x2) / sb x7,12(x2) / beq x1,x2,-16
  add_row(32'h4030D313, 32'h00000403, 1, 3, 6, 8'h40, 1, 3'b000, 0, 0,
          12'h403, 12'h403, 3'b000, 0, 2'b01, 3'b000);
  add_row(32'hFF811383, 32'hFFFFFFF8, 2, 24, 7, 8'h00, 1, 3'b011, 1, 0,
          12'hFF8, 12'hFF8, 3'b000, 1, 2'b01, 3'b011);
  add_row(32'h00710623, 32'h0000000C, 2, 7, 12, 8'h00, 0, 3'b000, 0, 1,
          12'h00C, 12'h00C, 3'b000, 1, 2'b01, 3'b100);
  add_row(32'hFE2088E3, 32'hFFFFFFF0, 1, 2, 17, 8'h03, 0, 3'b000, 0, 0,
          12'hFF0, 12'hFF0, 3'b011, 3, 2'b00, 3'b000);
  // jal x1,2048 / jalr x0,4(x1) / csrrw x5,mtvec,x6 / csrrs x8,mepc,x0
  add_row(32'h001000EF, 32'h00000800, 0, 1, 1, 8'h00, 1, 3'b001, 0, 0,
          12'h800, 12'h800, 3'b001, 0, 2'b00, 3'b000);
  add_row(32'h00408067, 32'h00000004, 1, 4, 0, 8'h00, 1, 3'b001, 0, 0,
          12'h004, 12'h004, 3'b010, 0, 2'b01, 3'b000);
  add_row(32'h305312F3, 32'h00000305, 6, 0, 5, 8'h00, 1, 3'b100, 0, 0,
          12'h305, 12'h305, 3'b000, 2, 2'b00, 3'b000);
  add_row(32'h34102473, 32'h00000341, 0, 1, 8, 8'h04, 1, 3'b100, 0, 0,
          12'h341, 12'h341, 3'b000, 2, 2'b10, 3'b000);
  // ecall / mret / auipc x9,0xfffff / andi x10,x9,0xf0
  add_row(32'h00000073, 32'h00000000, 0, 0, 0, 8'h00, 0, 3'b000, 0, 0,
          12'h305, 12'h342, 3'b100, 2, 2'b00, 3'b000);
  add_row(32'h30200073, 32'h00000000, 0, 2, 0, 8'h00, 0, 3'b000, 0, 0,
          12'h341, 12'h000, 3'b100, 2, 2'b00, 3'b000);
  add_row(32'hFFFFF497, 32'hFFFFF000, 31, 31, 9, 8'h00, 1, 3'b010, 0, 0,
          12'h000, 12'h000, 3'b000, 0, 2'b00, 3'b000);
  add_row(32'h0F04F513, 32'h000000F0, 9, 16, 10, 8'h08, 1, 3'b000, 0, 0,
          12'h0F0, 12'h0F0, 3'b000, 0, 2'b01, 3'b000);
endtask

`endif

//--- frontend_tb.sv
`timescale 1ns/1ps
`include "rv_config.svh"
`default_nettype none

module frontend_tb
  import rv_pkg::*;
;

  `include "tb_decode_table.svh"

  localparam logic [31:0] NOP_WORD = 32'h0000_0013;
  localparam int WATCHDOG_NS = 20 * (NUM_ROWS + 20) * 10;

  logic clock, arst_n, run, stall, imem_req, dec_valid, suffix_b, suffix_h, sext;
  logic r_wen, csr_wen1, csr_wen2, csr_wdata1_sel, csr_wdata2_sel, mem_ren, mem_wen;
  addr_t imem_addr, dec_pc, mem_addr_q;
  word_t imem_rdata, imm;
  npc_sel_t npc_sel;
  opnd_sel_t alu_operand2_sel;
  reg_idx_t rs1, rs2, rd;
  wdata_sel_t r_wdata_sel;
  csr_addr_t csr_s, csr_d1, csr_d2;
  alu_op_t alu_opcode;
  count_t count_calc, count_ls, count_csr;
  logic mem_req_q;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  integer seed = 91727;

  tb_clock_gen clk0 (.clock(clock));

  frontend_top dut0 (.*);

  function automatic word_t fetch_word(input addr_t addr);
    if ((addr >> 2) < NUM_ROWS) begin
      return t_inst[addr >> 2];
    end
    return NOP_WORD;
  endfunction

  // instruction memory answers one cycle after the request
  always @(negedge clock) begin
    mem_req_q  <= imem_req;
    mem_addr_q <= imem_addr;
  end

  always @(posedge clock) begin
    #1;
    if (mem_req_q) begin
      imem_rdata = fetch_word(mem_addr_q);
    end
  end

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: pc %h %s got %h expected %h", $time, dec_pc, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_row(input int i);
    logic is_ecall;
    is_ecall = (t_inst[i] == 32'h0000_0073);
    compare_field("imm", imm, t_imm[i]);
    compare_field("rs1", rs1, t_rs1[i]);
    compare_field("rs2", rs2, t_rs2[i]);
    compare_field("rd", rd, t_rd[i]);
    compare_field("alu_opcode", alu_opcode, t_alu[i]);
    compare_field("r_wen", r_wen, t_rwen[i]);
    compare_field("r_wdata_sel", r_wdata_sel, t_wsel[i]);
    compare_field("mem_ren", mem_ren, t_mren[i]);
    compare_field("mem_wen", mem_wen, t_mwen[i]);
    compare_field("csr_s", csr_s, t_csr_s[i]);
    compare_field("csr_d1", csr_d1, t_csr_d[i]);
    compare_field("csr_d2", csr_d2, is_ecall ? 12'h341 : t_csr_d[i]);
    compare_field("csr_wen1", csr_wen1, (t_class[i] == 2) && (t_inst[i] != 32'h3020_0073));
    compare_field("csr_wen2", csr_wen2, is_ecall);
    compare_field("csr_wdata1_sel", csr_wdata1_sel, is_ecall);
    compare_field("csr_wdata2_sel", csr_wdata2_sel, is_ecall);
    compare_field("npc_sel", npc_sel, t_npc[i]);
    compare_field("alu_operand2_sel", alu_operand2_sel, t_opnd[i]);
    compare_field("suffix_b", suffix_b, t_size[i][2]);
    compare_field("suffix_h", suffix_h, t_size[i][1]);
    compare_field("sext", sext, t_size[i][0]);
  endtask

  // strobes must be quiet in any cycle without a decoded instruction
  task automatic check_idle();
    if (r_wen || csr_wen1 || csr_wen2 || mem_ren || mem_wen) begin
      $display("[FAIL] %0t: strobe high while dec_valid is low", $time);
      errors++;
    end
  endtask

  task automatic run_program(input string name, input logic random_stall);
    int start_errors;
    int decoded;
    int calc_exp;
    int ls_exp;
    int sys_exp;
    int rnd;
    start_errors = errors;
    decoded = 0;
    calc_exp = 0;
    ls_exp = 0;
    sys_exp = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      calc_exp += (t_class[i] == 0);
      ls_exp += (t_class[i] == 1);
      sys_exp += (t_class[i] == 2);
    end
    @(posedge clock);
    #1;
    arst_n = 1'b0;
    run = 1'b0;
    stall = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    arst_n = 1'b1;
    @(negedge clock);
    if (dec_valid || imem_req || count_calc != 0 || count_ls != 0 || count_csr != 0) begin
      $display("[FAIL] %0t: outputs not cleared by reset", $time);
      errors++;
    end
    check_idle();
    // main phase runs until every table row has been decoded
    while (decoded < NUM_ROWS) begin
      @(posedge clock);
      #1;
      run = 1'b1;
      rnd = $random(seed);
      stall = random_stall ? rnd[0] : 1'b0;
      @(negedge clock);
      if (dec_valid) begin
        compare_field("dec_pc", dec_pc, 32'(decoded * 4));
        check_row(decoded);
        decoded++;
      end else begin
        check_idle();
      end
    end
    // the trailing words of the drain phase are nops
    for (int c = 0; c < `RV_BUF_DEPTH + 3 + 10; c++) begin
      @(posedge clock);
      #1;
      run = 1'b0;
      stall = 1'b0;
      @(negedge clock);
      if (dec_valid && c >= `RV_BUF_DEPTH + 3) begin
        $display("[FAIL] %0t: dec_valid still active after fetch was stopped", $time);
        errors++;
      end else if (dec_valid) begin
        compare_field("dec_pc", dec_pc, 32'(decoded * 4));
        compare_field("imm", imm, 32'h0);
        compare_field("rd", rd, 32'h0);
        decoded++;
        calc_exp++;
      end else begin
        check_idle();
      end
    end
    compare_field("count_calc", count_calc, calc_exp);
    compare_field("count_ls", count_ls, ls_exp);
    compare_field("count_csr", count_csr, sys_exp);
    tests_run++;
    if (errors != start_errors) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - start_errors);
    end else begin
      $display("test %s: passed, %0d instructions decoded", name, decoded);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    run = 1'b0;
    stall = 1'b0;
    imem_rdata = NOP_WORD;
    fill_table();
    run_program("stall_low", 1'b0);
    run_program("random_stall", 1'b1);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("the run timed out before all tests finished");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
rv_pkg.sv
inst_fetch.sv
fetch_buffer.sv
inst_decode.sv
frontend_top.sv
tb_clock_gen.sv
frontend_tb.sv
